// ==== hdl/rv_exec_pkg.sv ====
package rv_exec_pkg;

  // RV32I widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // alu operation select, pass_b carries the immediate through for lui
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_and    = 4'd2,
    alu_or     = 4'd3,
    alu_xor    = 4'd4,
    alu_sll    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_slt    = 4'd8,
    alu_sltu   = 4'd9,
    alu_pass_b = 4'd10
  } alu_op_t;

  // branch conditions, encoded as funct3
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } br_cond_t;

  // first alu operand source
  typedef enum logic [1:0] {
    op1_rs1  = 2'd0,
    op1_pc   = 2'd1,
    op1_zero = 2'd2
  } op1_sel_t;

  // decode to execute pipeline register contents
  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       rd1;
    logic [xlen-1:0]       rd2;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    alu_op_t               alu_op;
    logic                  alu_src_imm;
    op1_sel_t              op1_sel;
    logic                  jump;
    logic                  jalr;
    logic                  branch;
    br_cond_t              br_cond;
    logic                  reg_write;
    logic [1:0]            result_src;
    logic                  mem_write;
    logic [2:0]            mem_ctrl;
  } id_ex_t;

  // one forwarding source, from memory or writeback
  typedef struct packed {
    logic                  valid;
    logic                  reg_write;
    logic                  is_load;
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       data;
  } fwd_src_t;

  // execute to memory pipeline register contents
  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc_plus4;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       write_data;
    logic [reg_addr_w-1:0] rd;
    logic                  reg_write;
    logic [1:0]            result_src;
    logic                  mem_write;
    logic [2:0]            mem_ctrl;
  } ex_mem_t;

  // forwarding unit result
  typedef struct packed {
    logic [xlen-1:0] value;
    logic            hazard;
  } fwd_out_t;

endpackage

// ==== hdl/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward
  import rv_exec_pkg::*;
(
  input  logic                  instr_valid,
  input  logic [reg_addr_w-1:0] src_idx,
  input  logic [xlen-1:0]       reg_value,
  input  fwd_src_t              mem_fwd,
  input  fwd_src_t              wb_fwd,
  output fwd_out_t              result
);

  logic mem_hit;
  logic wb_hit;

  // a later stage holds a pending write to this source register
  function automatic logic src_matches(fwd_src_t src, logic [reg_addr_w-1:0] idx);
    logic live;
    live = src.valid && src.reg_write;
    return live && (idx != '0) && (src.dest == idx);
  endfunction

  assign mem_hit = src_matches(mem_fwd, src_idx);
  assign wb_hit  = src_matches(wb_fwd, src_idx);

  always_comb begin
    result.hazard = 1'b0;
    if (mem_hit) begin
      // load data is not back yet so the value is meaningless under hazard
      result.value  = mem_fwd.data;
      result.hazard = instr_valid && mem_fwd.is_load;
    end else if (wb_hit) begin
      result.value = wb_fwd.data;
    end else begin
      result.value = reg_value;
    end
  end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu
  import rv_exec_pkg::*;
(
  input  logic [xlen-1:0] op_a,
  input  logic [xlen-1:0] op_b,
  input  alu_op_t         op,
  output logic [xlen-1:0] result,
  output logic            zero,
  output logic            lt_signed,
  output logic            lt_unsigned
);

  logic [xlen:0] diff;
  logic [4:0]    shamt;

  // one subtractor feeds sub, slt, sltu and the branch flags
  assign diff  = {1'b0, op_a} - {1'b0, op_b};
  assign shamt = op_b[4:0];

  assign zero        = (diff[xlen-1:0] == '0);
  assign lt_unsigned = diff[xlen];
  // differing signs decide by the sign of op_a alone
  assign lt_signed   = (op_a[xlen-1] != op_b[xlen-1]) ? op_a[xlen-1] : diff[xlen-1];

  always_comb begin
    case (op)
      alu_add: begin
        result = op_a + op_b;
      end
      alu_sub: begin
        result = diff[xlen-1:0];
      end
      alu_and: begin
        result = op_a & op_b;
      end
      alu_or: begin
        result = op_a | op_b;
      end
      alu_xor: begin
        result = op_a ^ op_b;
      end
      alu_sll: begin
        result = op_a << shamt;
      end
      alu_srl: begin
        result = op_a >> shamt;
      end
      alu_sra: begin
        result = $signed(op_a) >>> shamt;
      end
      alu_slt: begin
        result = {{(xlen-1){1'b0}}, lt_signed};
      end
      alu_sltu: begin
        result = {{(xlen-1){1'b0}}, lt_unsigned};
      end
      alu_pass_b: begin
        result = op_b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// ==== hdl/exec_datapath.sv ====
`timescale 1ns/1ps

module exec_datapath
  import rv_exec_pkg::*;
(
  input  id_ex_t          id_ex,
  input  fwd_out_t        fwd_a,
  input  fwd_out_t        fwd_b,
  output ex_mem_t         next_ex_mem,
  output logic            redirect,
  output logic [xlen-1:0] redirect_pc
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  alu_op_t         alu_op;
  logic [xlen-1:0] alu_result;
  logic            zero;
  logic            lt_signed;
  logic            lt_unsigned;
  logic            br_taken;
  logic [xlen-1:0] jalr_sum;

  // operand muxes
  always_comb begin
    case (id_ex.op1_sel)
      op1_rs1: op_a = fwd_a.value;
      op1_pc:  op_a = id_ex.pc;
      default: op_a = '0;
    endcase
    op_b   = id_ex.alu_src_imm ? id_ex.imm : fwd_b.value;
    alu_op = id_ex.alu_op;

    // branches always compare rs1 against rs2 with a subtraction
    if (id_ex.branch) begin
      op_a   = fwd_a.value;
      op_b   = fwd_b.value;
      alu_op = alu_sub;
    end
  end

  alu u_alu (
    .op_a        (op_a),
    .op_b        (op_b),
    .op          (alu_op),
    .result      (alu_result),
    .zero        (zero),
    .lt_signed   (lt_signed),
    .lt_unsigned (lt_unsigned)
  );

  // branch resolution from the alu flags
  always_comb begin
    case (id_ex.br_cond)
      br_beq:  br_taken = zero;
      br_bne:  br_taken = !zero;
      br_blt:  br_taken = lt_signed;
      br_bge:  br_taken = !lt_signed;
      br_bltu: br_taken = lt_unsigned;
      br_bgeu: br_taken = !lt_unsigned;
      default: br_taken = 1'b0;
    endcase

    if (id_ex.branch) begin
      assert (id_ex.br_cond inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu})
        else $error("exec_datapath: illegal br_cond %b", id_ex.br_cond);
    end
  end

  assign redirect = id_ex.valid && (id_ex.jump || (id_ex.branch && br_taken));

  // jalr target has bit 0 cleared
  assign jalr_sum    = fwd_a.value + id_ex.imm;
  assign redirect_pc = id_ex.jalr ? {jalr_sum[xlen-1:1], 1'b0} : id_ex.pc + id_ex.imm;

  always_comb begin
    next_ex_mem.valid      = id_ex.valid;
    next_ex_mem.pc_plus4   = id_ex.pc + 32'd4;
    next_ex_mem.alu_result = alu_result;
    next_ex_mem.write_data = fwd_b.value;
    next_ex_mem.rd         = id_ex.rd;
    next_ex_mem.reg_write  = id_ex.reg_write;
    next_ex_mem.result_src = id_ex.result_src;
    next_ex_mem.mem_write  = id_ex.mem_write;
    next_ex_mem.mem_ctrl   = id_ex.mem_ctrl;
  end

endmodule

// ==== hdl/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg
  import rv_exec_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    enable,
  input  logic    bubble,
  input  ex_mem_t next_ex_mem,
  output ex_mem_t ex_mem
);

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem <= '0;
    end else if (enable) begin
      // a bubble loads an all-zero entry, so valid drops with it
      if (bubble) begin
        ex_mem <= '0;
      end else begin
        ex_mem <= next_ex_mem;
      end
    end
  end

  // memory stall must freeze the whole entry
  hold_stable: assert property (
    @(posedge clk) disable iff (reset)
    !enable |=> $stable(ex_mem)
  ) else $error("ex_mem_reg: contents changed while enable was low");

  // bubble seen by memory stage as an empty slot
  bubble_empty: assert property (
    @(posedge clk) disable iff (reset)
    (enable && bubble) |=> !ex_mem.valid
  ) else $error("ex_mem_reg: bubble left valid high");

  // nothing in flight right after reset
  reset_clears: assert property (
    @(posedge clk)
    reset |=> !ex_mem.valid
  ) else $error("ex_mem_reg: valid high after reset");

endmodule

// ==== hdl/exec_stage_top.sv ====
`timescale 1ns/1ps

module exec_stage_top
  import rv_exec_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  id_ex_t          id_ex,
  input  fwd_src_t        mem_fwd,
  input  fwd_src_t        wb_fwd,
  input  logic            mem_ready,
  output ex_mem_t         ex_mem,
  output logic            redirect,
  output logic [xlen-1:0] redirect_pc,
  output logic            stall
);

  fwd_out_t fwd_a;
  fwd_out_t fwd_b;
  ex_mem_t  next_ex_mem;

  // rs1 and rs2 are resolved independently
  operand_forward fwd_rs1 (
    .instr_valid (id_ex.valid),
    .src_idx     (id_ex.rs1),
    .reg_value   (id_ex.rd1),
    .mem_fwd     (mem_fwd),
    .wb_fwd      (wb_fwd),
    .result      (fwd_a)
  );

  operand_forward fwd_rs2 (
    .instr_valid (id_ex.valid),
    .src_idx     (id_ex.rs2),
    .reg_value   (id_ex.rd2),
    .mem_fwd     (mem_fwd),
    .wb_fwd      (wb_fwd),
    .result      (fwd_b)
  );

  assign stall = fwd_a.hazard | fwd_b.hazard;

  exec_datapath u_datapath (
    .id_ex       (id_ex),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .next_ex_mem (next_ex_mem),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  // load-use hazard becomes a bubble, memory stall holds the register
  ex_mem_reg u_ex_mem_reg (
    .clk         (clk),
    .reset       (reset),
    .enable      (mem_ready),
    .bubble      (stall),
    .next_ex_mem (next_ex_mem),
    .ex_mem      (ex_mem)
  );

endmodule

// ==== verif/tb_exec_types.svh ====
`ifndef TB_EXEC_TYPES_SVH
`define TB_EXEC_TYPES_SVH

// expected responses for one applied row
typedef struct packed {
  logic [rv_exec_pkg::xlen-1:0] alu_result;
  logic [rv_exec_pkg::xlen-1:0] write_data;
  logic                         redirect;
  logic [rv_exec_pkg::xlen-1:0] redirect_pc;
  logic                         stall;
} expect_t;

`endif

// ==== verif/exec_checker.sv ====
`timescale 1ns/1ps
`include "tb_exec_types.svh"

module exec_checker
  import rv_exec_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  id_ex_t          id_ex,
  input  logic            mem_ready,
  input  ex_mem_t         ex_mem,
  input  logic            redirect,
  input  logic [xlen-1:0] redirect_pc,
  input  logic            stall,
  input  expect_t         expected,
  input  logic            strobe,
  output int              checks,
  output int              comb_errors,
  output int              reg_errors
);

  // predicted contents of the last accepted ex_mem entry
  ex_mem_t m_exp;
  logic    m_full;

  initial begin
    checks      = 0;
    comb_errors = 0;
    reg_errors  = 0;
    m_exp       = '0;
    m_full      = 1'b0;
  end

  task automatic compare_field(input string name, input logic [31:0] want,
                               input logic [31:0] got, input logic registered);
    checks++;
    if (got !== want) begin
      $display("** Error %s expected %h actual %h at %0t ns", name, want, got, $time);
      if (registered) begin
        reg_errors++;
      end else begin
        comb_errors++;
      end
    end
  endtask

  // inputs settle 1 ns after the rising edge and are stable by the falling edge
  always @(negedge clk) begin
    if (reset) begin
      compare_field("ex_mem.valid", 32'h0, 32'(ex_mem.valid), 1'b1);
      m_exp  = '0;
      m_full = 1'b0;
    end else begin
      compare_field("ex_mem.valid", 32'(m_exp.valid), 32'(ex_mem.valid), 1'b1);
      // an idle slot carries no meaningful payload
      if (m_full) begin
        compare_field("ex_mem.pc_plus4", m_exp.pc_plus4, ex_mem.pc_plus4, 1'b1);
        compare_field("ex_mem.alu_result", m_exp.alu_result, ex_mem.alu_result, 1'b1);
        compare_field("ex_mem.write_data", m_exp.write_data, ex_mem.write_data, 1'b1);
        compare_field("ex_mem.rd", 32'(m_exp.rd), 32'(ex_mem.rd), 1'b1);
        compare_field("ex_mem.reg_write", 32'(m_exp.reg_write), 32'(ex_mem.reg_write), 1'b1);
        compare_field("ex_mem.result_src", 32'(m_exp.result_src), 32'(ex_mem.result_src), 1'b1);
        compare_field("ex_mem.mem_write", 32'(m_exp.mem_write), 32'(ex_mem.mem_write), 1'b1);
        compare_field("ex_mem.mem_ctrl", 32'(m_exp.mem_ctrl), 32'(ex_mem.mem_ctrl), 1'b1);
      end

      if (strobe) begin
        compare_field("stall", 32'(expected.stall), 32'(stall), 1'b0);
        compare_field("redirect", 32'(expected.redirect), 32'(redirect), 1'b0);
        // target only matters when taken
        if (expected.redirect) begin
          compare_field("redirect_pc", expected.redirect_pc, redirect_pc, 1'b0);
        end
      end

      // next edge loads a result or a bubble, or holds on a memory stall
      if (mem_ready) begin
        if (expected.stall) begin
          // a load-use bubble is an all-zero entry
          m_exp  = '0;
          m_full = 1'b1;
        end else begin
          m_exp.valid      = id_ex.valid;
          m_exp.pc_plus4   = id_ex.pc + 32'd4;
          m_exp.alu_result = expected.alu_result;
          m_exp.write_data = expected.write_data;
          m_exp.rd         = id_ex.rd;
          m_exp.reg_write  = id_ex.reg_write;
          m_exp.result_src = id_ex.result_src;
          m_exp.mem_write  = id_ex.mem_write;
          m_exp.mem_ctrl   = id_ex.mem_ctrl;
          m_full           = id_ex.valid;
        end
      end
    end
  end

endmodule

// ==== verif/tb_exec_stage.sv ====
`timescale 1ns/1ps
`include "tb_exec_types.svh"

module tb_exec_stage
  import rv_exec_pkg::*;
();

  typedef struct packed {
    id_ex_t   id_ex;
    fwd_src_t mem_fwd;
    fwd_src_t wb_fwd;
    logic     mem_ready;
    expect_t  exp;
  } row_t;

  logic            clk = 1'b0;
  logic            reset;
  id_ex_t          id_ex;
  fwd_src_t        mem_fwd;
  fwd_src_t        wb_fwd;
  logic            mem_ready;
  ex_mem_t         ex_mem;
  logic            redirect;
  logic [xlen-1:0] redirect_pc;
  logic            stall;
  expect_t         expected;
  logic            strobe;
  int              checks;
  int              comb_errors;
  int              reg_errors;

  row_t       rows[$];
  fwd_src_t   cur_mem = '0;
  fwd_src_t   cur_wb = '0;
  logic [7:0] lfsr_state = 8'd58;
  logic       table_ready = 1'b0;

  always #10 clk = ~clk;

  exec_stage_top DUT (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .mem_fwd     (mem_fwd),
    .wb_fwd      (wb_fwd),
    .mem_ready   (mem_ready),
    .ex_mem      (ex_mem),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .stall       (stall)
  );

  exec_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .mem_ready   (mem_ready),
    .ex_mem      (ex_mem),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .stall       (stall),
    .expected    (expected),
    .strobe      (strobe),
    .checks      (checks),
    .comb_errors (comb_errors),
    .reg_errors  (reg_errors)
  );

  // register form reading x1 and x2 into x10
  function automatic id_ex_t alu_instr(alu_op_t op, logic [31:0] a, logic [31:0] b);
    id_ex_t id;
    id           = '0;
    id.valid     = 1'b1;
    id.pc        = 32'h1000;
    id.rs1       = 5'd1;
    id.rs2       = 5'd2;
    id.rd        = 5'd10;
    id.rd1       = a;
    id.rd2       = b;
    id.alu_op    = op;
    id.reg_write = 1'b1;
    return id;
  endfunction

  function automatic id_ex_t imm_instr(alu_op_t op, logic [31:0] a, logic [31:0] imm);
    id_ex_t id;
    id             = alu_instr(op, a, 32'h0);
    id.imm         = imm;
    id.alu_src_imm = 1'b1;
    return id;
  endfunction

  function automatic fwd_src_t fwd_entry(logic is_load, logic [4:0] dest, logic [31:0] data);
    fwd_src_t f;
    f.valid     = 1'b1;
    f.reg_write = 1'b1;
    f.is_load   = is_load;
    f.dest      = dest;
    f.data      = data;
    return f;
  endfunction

  // galois form with taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(logic [7:0] s);
    logic [7:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 8'hb8;
    end
    return n;
  endfunction

  task automatic push_row(input id_ex_t id, input logic [31:0] alu, input logic [31:0] wd,
                          input logic redir, input logic [31:0] rpc, input logic stl);
    row_t r;
    r.id_ex             = id;
    r.mem_fwd           = cur_mem;
    r.wb_fwd            = cur_wb;
    r.mem_ready         = 1'b1;
    r.exp.alu_result    = alu;
    r.exp.write_data    = wd;
    r.exp.redirect      = redir;
    r.exp.redirect_pc   = rpc;
    r.exp.stall         = stl;
    rows.push_back(r);
  endtask

  task automatic add_row(input id_ex_t id, input logic [31:0] alu, input logic [31:0] wd);
    push_row(id, alu, wd, 1'b0, 32'h0, 1'b0);
  endtask

  // branch target is always pc 0x1000 plus 0x40
  task automatic add_branch_row(input br_cond_t cond, input logic [31:0] a,
                                input logic [31:0] b, input logic [31:0] diff,
                                input logic taken);
    id_ex_t id;
    id           = alu_instr(alu_sub, a, b);
    id.branch    = 1'b1;
    id.br_cond   = cond;
    id.imm       = 32'h40;
    id.reg_write = 1'b0;
    push_row(id, diff, b, taken, 32'h1040, 1'b0);
  endtask

  task automatic fill_table();
    id_ex_t id;
    // invalid jump with a matching load must stay quiet
    cur_mem = fwd_entry(1'b1, 5'd1, 32'h0);
    id = alu_instr(alu_add, 32'h1, 32'h2);
    id.valid = 1'b0;
    id.jump  = 1'b1;
    push_row(id, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0);
    cur_mem = '0;

    add_row(alu_instr(alu_add, 32'h12345678, 32'h11111111), 32'h23456789, 32'h11111111);
    add_row(alu_instr(alu_sub, 32'h5, 32'h7), 32'hfffffffe, 32'h7);
    add_row(alu_instr(alu_and, 32'hf0f0f0f0, 32'hff00ff00), 32'hf000f000, 32'hff00ff00);
    add_row(alu_instr(alu_or, 32'hf0f0f0f0, 32'hff00ff00), 32'hfff0fff0, 32'hff00ff00);
    add_row(alu_instr(alu_xor, 32'hf0f0f0f0, 32'hff00ff00), 32'h0ff00ff0, 32'hff00ff00);
    add_row(imm_instr(alu_sll, 32'h1, 32'h24), 32'h10, 32'h0);
    add_row(alu_instr(alu_srl, 32'h80000000, 32'h4), 32'h08000000, 32'h4);
    add_row(imm_instr(alu_sra, 32'h80000000, 32'h4), 32'hf8000000, 32'h0);
    add_row(alu_instr(alu_slt, 32'hffffffff, 32'h1), 32'h1, 32'h1);
    add_row(alu_instr(alu_sltu, 32'hffffffff, 32'h1), 32'h0, 32'h1);
    add_row(imm_instr(alu_pass_b, 32'h55, 32'h12345000), 32'h12345000, 32'h0);
    id = imm_instr(alu_add, 32'h55, 32'h2000);
    id.op1_sel = op1_pc;
    add_row(id, 32'h3000, 32'h0);
    id = imm_instr(alu_add, 32'h55, 32'habcde000);
    id.op1_sel = op1_zero;
    add_row(id, 32'habcde000, 32'h0);

    // memory beats writeback and writeback alone feeds rs2
    cur_mem = fwd_entry(1'b0, 5'd1, 32'h100);
    cur_wb  = fwd_entry(1'b0, 5'd1, 32'h200);
    add_row(alu_instr(alu_add, 32'h1, 32'h2), 32'h102, 32'h2);
    cur_mem = fwd_entry(1'b0, 5'd5, 32'h999);
    cur_wb  = fwd_entry(1'b0, 5'd2, 32'h300);
    // store word carrying the forwarded rs2
    id = alu_instr(alu_add, 32'h1, 32'h2);
    id.reg_write = 1'b0;
    id.mem_write = 1'b1;
    id.mem_ctrl  = 3'b010;
    add_row(id, 32'h301, 32'h300);
    cur_mem = fwd_entry(1'b1, 5'd0, 32'hdead);
    cur_wb  = '0;
    id = alu_instr(alu_add, 32'h7, 32'h2);
    id.rs1 = 5'd0;
    add_row(id, 32'h9, 32'h2);

    // load-use on rs1 then rs2 with each retried once the load reaches writeback
    cur_mem = fwd_entry(1'b1, 5'd1, 32'h0);
    push_row(alu_instr(alu_add, 32'h1, 32'h2), 32'h0, 32'h0, 1'b0, 32'h0, 1'b1);
    cur_mem = '0;
    cur_wb  = fwd_entry(1'b0, 5'd1, 32'h40);
    add_row(alu_instr(alu_add, 32'h1, 32'h2), 32'h42, 32'h2);
    cur_mem = fwd_entry(1'b1, 5'd2, 32'h0);
    cur_wb  = '0;
    push_row(alu_instr(alu_add, 32'h1, 32'h2), 32'h0, 32'h0, 1'b0, 32'h0, 1'b1);
    cur_mem = '0;
    cur_wb  = fwd_entry(1'b0, 5'd2, 32'h50);
    add_row(alu_instr(alu_add, 32'h1, 32'h2), 32'h51, 32'h50);
    cur_wb  = '0;

    add_branch_row(br_beq, 32'hffffffff, 32'h00000001, 32'hfffffffe, 1'b0);
    add_branch_row(br_beq, 32'h00000005, 32'h00000005, 32'h00000000, 1'b1);
    add_branch_row(br_bne, 32'hffffffff, 32'h00000001, 32'hfffffffe, 1'b1);
    add_branch_row(br_bne, 32'h00000005, 32'h00000005, 32'h00000000, 1'b0);
    add_branch_row(br_blt, 32'hffffffff, 32'h00000001, 32'hfffffffe, 1'b1);
    add_branch_row(br_blt, 32'h00000001, 32'hffffffff, 32'h00000002, 1'b0);
    add_branch_row(br_bge, 32'hffffffff, 32'h00000001, 32'hfffffffe, 1'b0);
    add_branch_row(br_bge, 32'h00000001, 32'hffffffff, 32'h00000002, 1'b1);
    add_branch_row(br_bltu, 32'hffffffff, 32'h00000001, 32'hfffffffe, 1'b0);
    add_branch_row(br_bltu, 32'h00000001, 32'hffffffff, 32'h00000002, 1'b1);
    add_branch_row(br_bgeu, 32'hffffffff, 32'h00000001, 32'hfffffffe, 1'b1);
    add_branch_row(br_bgeu, 32'h00000001, 32'hffffffff, 32'h00000002, 1'b0);

    // jal then jalr with an odd sum, both linking pc plus 4
    id = imm_instr(alu_add, 32'h0, 32'h100);
    id.jump       = 1'b1;
    id.rd         = 5'd1;
    id.result_src = 2'b10;
    push_row(id, 32'h100, 32'h0, 1'b1, 32'h1100, 1'b0);
    id = imm_instr(alu_add, 32'h2001, 32'h10);
    id.pc         = 32'h3000;
    id.jump       = 1'b1;
    id.jalr       = 1'b1;
    id.result_src = 2'b10;
    push_row(id, 32'h2011, 32'h0, 1'b1, 32'h2010, 1'b0);
  endtask

  task automatic apply_row(input row_t r);
    id_ex     = r.id_ex;
    mem_fwd   = r.mem_fwd;
    wb_fwd    = r.wb_fwd;
    mem_ready = r.mem_ready;
    expected  = r.exp;
    strobe    = 1'b1;
  endtask

  task automatic drive_idle();
    id_ex     = '0;
    mem_fwd   = '0;
    wb_fwd    = '0;
    mem_ready = 1'b1;
    expected  = '0;
    strobe    = 1'b0;
  endtask

  initial begin
    row_t r;
    logic accepted;
    reset = 1'b1;
    drive_idle();
    fill_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    foreach (rows[i]) begin
      @(posedge clk);
      #1;
      apply_row(rows[i]);
    end

    // replay the first alu rows under random memory stalls until each is taken
    for (int i = 1; i <= 8; i++) begin
      accepted = 1'b0;
      while (!accepted) begin
        r = rows[i];
        r.mem_ready = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        @(posedge clk);
        #1;
        apply_row(r);
        accepted = r.mem_ready;
      end
    end

    @(posedge clk);
    #1;
    drive_idle();
    @(negedge clk);
    #1;
    $display("checks %0d, combinational errors %0d, ex_mem errors %0d",
             checks, comb_errors, reg_errors);
    if (comb_errors + reg_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    wait (table_ready === 1'b1);
    #((rows.size() + 40) * 20 * 4);
    $display("timeout: the run did not reach its end in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+verif
hdl/rv_exec_pkg.sv
hdl/operand_forward.sv
hdl/alu.sv
hdl/exec_datapath.sv
hdl/ex_mem_reg.sv
hdl/exec_stage_top.sv
verif/exec_checker.sv
verif/tb_exec_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module tb_exec_stage -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_exec_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
  exit 0
fi
exit 1
